//--- hw/saturn_bus_pkg.sv
package saturn_bus_pkg;

  // address loads carry five nibbles, low nibble first
  localparam int ADDR_NIBS = 5;
  localparam int ADDR_CNT_W = $clog2(ADDR_NIBS);

  // width of the device pointers
  localparam int BUS_AW = ADDR_NIBS * 4;

  // Saturn bus command codes
  typedef enum logic [3:0] {
    BUSCMD_PC_READ  = 4'h0,
    BUSCMD_DP_WRITE = 4'h1,
    BUSCMD_DP_READ  = 4'h2,
    BUSCMD_LOAD_PC  = 4'h4,
    BUSCMD_LOAD_DP  = 4'h5,
    BUSCMD_NOP      = 4'hf
  } bus_cmd_e;

  // one nibble on the bus, either a command or an address/data value
  typedef union packed {
    bus_cmd_e   cmd;
    logic [3:0] val;
  } bus_nib_u;

  // controller to device bus
  typedef struct packed {
    logic     strobe;
    // set when nib holds a command
    logic     cmd_data;
    bus_nib_u nib;
  } bus_word_t;

endpackage

//--- hw/saturn_core_pkg.sv
package saturn_core_pkg;

  // core side address width
  localparam int REQ_AW = 20;

  // transfers run from 1 to MAX_XFER nibbles
  localparam int MAX_XFER = 16;
  localparam int CNT_W = $clog2(MAX_XFER);
  localparam int WDATA_W = MAX_XFER * 4;

  // bus device RAM, addresses wrap modulo its depth
  localparam int MEM_NIBS = 256;
  localparam int MEM_AW = $clog2(MEM_NIBS);

  // kinds of work the core can ask for
  typedef enum logic [1:0] {
    REQ_LOAD_PC  = 2'd0,
    REQ_DP_READ  = 2'd1,
    REQ_DP_WRITE = 2'd2
  } req_kind_e;

  // one core request
  typedef struct packed {
    req_kind_e            kind;
    logic [REQ_AW-1:0]    addr;
    // number of nibbles minus one
    logic [CNT_W-1:0]     count;
    // nibble 0 in the low bits
    logic [WDATA_W-1:0]   wdata;
  } core_req_t;

endpackage

//--- hw/bus_req_capture.sv
`timescale 1ns/10ps

module bus_req_capture (
  input  logic                               i_clk,
  input  logic                               do_cmd_reset,
  input  saturn_core_pkg::core_req_t         i_req,
  input  logic                               i_accept,
  input  logic                               i_take_wdata,
  output saturn_core_pkg::req_kind_e         o_req_kind,
  output logic [saturn_core_pkg::REQ_AW-1:0] o_addr,
  output logic [saturn_core_pkg::CNT_W-1:0]  o_count,
  output logic [3:0]                         o_wnib
);

  import saturn_core_pkg::*;

  req_kind_e          kind_q;
  logic [CNT_W-1:0]   count_q;
  logic [REQ_AW-1:0]  addr_q;
  logic [WDATA_W-1:0] wdata_q;

  // request kind and length steer the sequencer
  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      kind_q  <= REQ_LOAD_PC;
      count_q <= '0;
    end else if (i_accept) begin
      kind_q  <= i_req.kind;
      count_q <= i_req.count;
    end
  end

  // address and write data, shifted one nibble per take
  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      addr_q  <= i_req.addr;
      wdata_q <= i_req.wdata;
    end else if (i_take_wdata) begin
      wdata_q <= {4'h0, wdata_q[WDATA_W-1:4]};
    end
  end

  assign o_req_kind = kind_q;
  assign o_addr     = addr_q;
  assign o_count    = count_q;

  // head of the shift register is the next nibble to send
  assign o_wnib = wdata_q[3:0];

endmodule

//--- hw/bus_cmd_sequencer.sv
`timescale 1ns/10ps

module bus_cmd_sequencer (
  input  logic                               i_clk,
  input  logic                               do_cmd_reset,
  input  logic                               i_req_valid,
  input  logic                               i_fetch,
  input  saturn_core_pkg::req_kind_e         i_req_kind,
  input  logic [saturn_core_pkg::REQ_AW-1:0] i_addr,
  input  logic [saturn_core_pkg::CNT_W-1:0]  i_count,
  input  logic [3:0]                         i_wnib,
  output logic                               o_accept,
  output logic                               o_take_wdata,
  output logic                               o_stalled_by_bus,
  output saturn_bus_pkg::bus_word_t          o_bus
);

  import saturn_core_pkg::*;
  import saturn_bus_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SEND_CMD,
    SEND_ADDR,
    DP_XFER,
    SEND_DPW,
    RESUME_PC
  } seq_state_e;

  seq_state_e            state_q;
  logic [ADDR_CNT_W-1:0] addr_cnt_q;
  logic [CNT_W-1:0]      data_cnt_q;
  logic                  pc_loaded_q;
  logic                  stall_q;

  logic                  addr_last;
  logic                  xfer_last;
  logic                  is_write;
  logic                  fetch_go;
  bus_word_t             bus_d;

  // requests only get in while the bus is free
  assign o_accept = i_req_valid && !stall_q;

  assign addr_last = (addr_cnt_q == ADDR_CNT_W'(ADDR_NIBS - 1));
  assign xfer_last = (data_cnt_q == i_count);
  assign is_write  = (i_req_kind == REQ_DP_WRITE);

  // one fetch read per cycle, held off for a new request
  assign fetch_go = (state_q == IDLE) && !stall_q && i_fetch && pc_loaded_q && !i_req_valid;

  // write nibble leaves the capture as it goes on the bus
  assign o_take_wdata = (state_q == DP_XFER) && is_write;

  assign o_stalled_by_bus = stall_q;

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      state_q     <= IDLE;
      addr_cnt_q  <= '0;
      data_cnt_q  <= '0;
      pc_loaded_q <= 1'b0;
      stall_q     <= 1'b0;
    end else begin
      // stall holds one cycle past the last bus word
      stall_q <= o_accept || (state_q != IDLE);
      case (state_q)
        IDLE: begin
          if (o_accept) begin
            state_q <= SEND_CMD;
          end
        end
        SEND_CMD: begin
          addr_cnt_q <= '0;
          state_q    <= SEND_ADDR;
        end
        SEND_ADDR: begin
          addr_cnt_q <= addr_cnt_q + 1'b1;
          data_cnt_q <= '0;
          if (addr_last) begin
            case (i_req_kind)
              REQ_DP_READ:  state_q <= DP_XFER;
              REQ_DP_WRITE: state_q <= SEND_DPW;
              default: begin
                pc_loaded_q <= 1'b1;
                state_q     <= IDLE;
              end
            endcase
          end
        end
        SEND_DPW: begin
          data_cnt_q <= '0;
          state_q    <= DP_XFER;
        end
        DP_XFER: begin
          data_cnt_q <= data_cnt_q + 1'b1;
          if (xfer_last) begin
            state_q <= RESUME_PC;
          end
        end
        RESUME_PC: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // next bus word, one per state
  always_comb begin
    bus_d = '0;
    case (state_q)
      IDLE: begin
        // plain strobe reads at the device PC
        bus_d.strobe = fetch_go;
      end
      SEND_CMD: begin
        bus_d.strobe   = 1'b1;
        bus_d.cmd_data = 1'b1;
        bus_d.nib.cmd  = (i_req_kind == REQ_LOAD_PC) ? BUSCMD_LOAD_PC : BUSCMD_LOAD_DP;
      end
      SEND_ADDR: begin
        bus_d.strobe  = 1'b1;
        bus_d.nib.val = i_addr[{addr_cnt_q, 2'b00} +: 4];
      end
      SEND_DPW: begin
        bus_d.strobe   = 1'b1;
        bus_d.cmd_data = 1'b1;
        bus_d.nib.cmd  = BUSCMD_DP_WRITE;
      end
      DP_XFER: begin
        // reads carry no payload
        bus_d.strobe  = 1'b1;
        bus_d.nib.val = is_write ? i_wnib : 4'h0;
      end
      RESUME_PC: begin
        bus_d.strobe   = 1'b1;
        bus_d.cmd_data = 1'b1;
        bus_d.nib.cmd  = BUSCMD_PC_READ;
      end
      default: begin
        bus_d = '0;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      o_bus <= '0;
    end else begin
      o_bus <= bus_d;
    end
  end

endmodule

//--- hw/bus_nibble_memory.sv
`timescale 1ns/10ps

module bus_nibble_memory (
  input  logic                      i_clk,
  input  logic                      do_cmd_reset,
  input  saturn_bus_pkg::bus_word_t i_bus,
  output logic [3:0]                o_rd_nib,
  output logic                      o_rd_valid,
  output logic                      o_rd_is_data
);

  import saturn_bus_pkg::*;
  import saturn_core_pkg::*;

  logic [3:0]            ram [MEM_NIBS];
  bus_cmd_e              mode_q;
  logic [BUS_AW-1:0]     pc_q;
  logic [BUS_AW-1:0]     dp_q;
  logic [BUS_AW-1:0]     addr_sh_q;
  logic [ADDR_CNT_W-1:0] addr_cnt_q;

  logic                  cmd_stb;
  logic                  data_stb;
  logic                  loading;
  logic                  addr_last;
  logic                  do_read;
  logic                  do_write;
  logic [BUS_AW-1:0]     addr_full;
  logic [BUS_AW-1:0]     ptr;
  logic [MEM_AW-1:0]     ram_idx;

  assign cmd_stb  = i_bus.strobe && i_bus.cmd_data;
  assign data_stb = i_bus.strobe && !i_bus.cmd_data;

  assign loading   = (mode_q == BUSCMD_LOAD_PC) || (mode_q == BUSCMD_LOAD_DP);
  assign addr_last = (addr_cnt_q == ADDR_CNT_W'(ADDR_NIBS - 1));
  assign do_read   = data_stb && ((mode_q == BUSCMD_PC_READ) || (mode_q == BUSCMD_DP_READ));
  assign do_write  = data_stb && (mode_q == BUSCMD_DP_WRITE);

  // incoming nibble lands on top, low nibble arrived first
  assign addr_full = {i_bus.nib.val, addr_sh_q[BUS_AW-1:4]};

  // pointer wraps over the RAM depth
  assign ptr     = (mode_q == BUSCMD_PC_READ) ? pc_q : dp_q;
  assign ram_idx = ptr[MEM_AW-1:0];

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      mode_q     <= BUSCMD_NOP;
      pc_q       <= '0;
      dp_q       <= '0;
      addr_cnt_q <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= do_read;
      if (cmd_stb) begin
        case (i_bus.nib.cmd)
          BUSCMD_LOAD_PC, BUSCMD_LOAD_DP: begin
            mode_q     <= i_bus.nib.cmd;
            addr_cnt_q <= '0;
          end
          BUSCMD_PC_READ, BUSCMD_DP_READ, BUSCMD_DP_WRITE: begin
            mode_q <= i_bus.nib.cmd;
          end
          default: begin
            mode_q <= BUSCMD_NOP;
          end
        endcase
      end else if (data_stb) begin
        case (mode_q)
          BUSCMD_LOAD_PC, BUSCMD_LOAD_DP: begin
            addr_cnt_q <= addr_cnt_q + 1'b1;
            // full address in, switch to the matching read mode
            if (addr_last && (mode_q == BUSCMD_LOAD_PC)) begin
              pc_q   <= addr_full;
              mode_q <= BUSCMD_PC_READ;
            end else if (addr_last) begin
              dp_q   <= addr_full;
              mode_q <= BUSCMD_DP_READ;
            end
          end
          BUSCMD_PC_READ: pc_q <= pc_q + 1'b1;
          BUSCMD_DP_READ, BUSCMD_DP_WRITE: dp_q <= dp_q + 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (data_stb && loading) begin
      addr_sh_q <= addr_full;
    end
    if (do_write) begin
      ram[ram_idx] <= i_bus.nib.val;
    end
    if (do_read) begin
      o_rd_nib     <= ram[ram_idx];
      o_rd_is_data <= (mode_q == BUSCMD_DP_READ);
    end
  end

endmodule

//--- hw/saturn_bus_top.sv
`timescale 1ns/10ps

module saturn_bus_top (
  input  logic                       i_clk,
  input  logic                       do_cmd_reset,
  input  saturn_core_pkg::core_req_t i_req,
  input  logic                       i_req_valid,
  input  logic                       i_fetch,
  output logic                       o_stalled_by_bus,
  output logic [3:0]                 o_nibble,
  output logic                       o_nibble_valid,
  output logic                       o_nibble_is_data
);

  import saturn_core_pkg::*;
  import saturn_bus_pkg::*;

  req_kind_e         req_kind;
  logic [REQ_AW-1:0] req_addr;
  logic [CNT_W-1:0]  req_count;
  logic [3:0]        wnib;
  logic              accept;
  logic              take_wdata;
  bus_word_t         bus;

  bus_req_capture u_capture (
    .i_clk        (i_clk),
    .do_cmd_reset (do_cmd_reset),
    .i_req        (i_req),
    .i_accept     (accept),
    .i_take_wdata (take_wdata),
    .o_req_kind   (req_kind),
    .o_addr       (req_addr),
    .o_count      (req_count),
    .o_wnib       (wnib)
  );

  bus_cmd_sequencer u_sequencer (
    .i_clk            (i_clk),
    .do_cmd_reset     (do_cmd_reset),
    .i_req_valid      (i_req_valid),
    .i_fetch          (i_fetch),
    .i_req_kind       (req_kind),
    .i_addr           (req_addr),
    .i_count          (req_count),
    .i_wnib           (wnib),
    .o_accept         (accept),
    .o_take_wdata     (take_wdata),
    .o_stalled_by_bus (o_stalled_by_bus),
    .o_bus            (bus)
  );

  // far side of the bus
  bus_nibble_memory u_memory (
    .i_clk        (i_clk),
    .do_cmd_reset (do_cmd_reset),
    .i_bus        (bus),
    .o_rd_nib     (o_nibble),
    .o_rd_valid   (o_nibble_valid),
    .o_rd_is_data (o_nibble_is_data)
  );

endmodule

//--- tests/saturn_bus_chk.sv
`timescale 1ns/10ps

module saturn_bus_chk (
  input  logic                      i_clk,
  input  logic                      do_cmd_reset,
  input  logic                      i_accept,
  input  logic                      i_stalled,
  input  saturn_bus_pkg::bus_word_t i_bus
);

  import saturn_bus_pkg::*;

  int   fail_count = 0;
  logic load_pc_cmd;
  logic load_cmd;
  logic cmd_word;
  logic addr_stb;

  assign load_pc_cmd = i_bus.strobe && i_bus.cmd_data && (i_bus.nib.cmd == BUSCMD_LOAD_PC);
  assign load_cmd    = load_pc_cmd
                       || (i_bus.strobe && i_bus.cmd_data && (i_bus.nib.cmd == BUSCMD_LOAD_DP));
  assign cmd_word    = i_bus.strobe && i_bus.cmd_data;
  assign addr_stb    = i_bus.strobe && !i_bus.cmd_data;

  // stall comes up on the edge after an accept and a load command follows
  a_stall_after_accept: assert property (
    @(posedge i_clk) disable iff (do_cmd_reset) i_accept |=> i_stalled ##1 load_cmd
  ) else begin
    $error("stall or load command did not follow an accepted request");
    fail_count++;
  end

  // a new request never lands on a transfer still going out on the bus
  a_no_accept_stalled: assert property (
    @(posedge i_clk) disable iff (do_cmd_reset) i_accept |-> !i_stalled && !cmd_word
  ) else begin
    $error("request accepted while the bus was busy");
    fail_count++;
  end

  // every load command is followed by ADDR_NIBS address strobes
  for (genvar k = 1; k <= ADDR_NIBS; k++) begin : g_addr_nib
    a_addr_nib: assert property (
      @(posedge i_clk) disable iff (do_cmd_reset) $past(load_cmd, k) |-> addr_stb
    ) else begin
      $error("address nibble %0d missing after a load command", k);
      fail_count++;
    end
  end

  // LOAD_PC has nothing behind its address
  a_pc_load_ends: assert property (
    @(posedge i_clk) disable iff (do_cmd_reset) $past(load_pc_cmd, ADDR_NIBS + 1) |-> !i_bus.strobe
  ) else begin
    $error("extra bus strobe after the LOAD_PC address");
    fail_count++;
  end

endmodule

//--- tests/bus_scoreboard.sv
`timescale 1ns/10ps

module bus_scoreboard (
  input  logic                       i_clk,
  input  logic                       do_cmd_reset,
  input  saturn_core_pkg::core_req_t i_req,
  input  logic                       i_req_valid,
  input  logic                       i_fetch,
  input  logic                       i_stalled,
  input  logic [3:0]                 i_nibble,
  input  logic                       i_nibble_valid,
  input  logic                       i_nibble_is_data,
  output int                         o_errors,
  output int                         o_checks
);

  import saturn_core_pkg::*;
  import saturn_bus_pkg::*;

  logic [3:0]        ref_mem [MEM_NIBS];
  logic              written [MEM_NIBS];
  logic [MEM_AW-1:0] rd_addrs [$];
  logic [REQ_AW-1:0] ref_pc;
  logic              pc_loaded;
  logic [1:0]        fetch_pipe;
  logic              exp_stall;
  logic [MEM_AW-1:0] idx;
  int                stall_left;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    o_checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      o_errors++;
    end
  endtask

  task automatic protocol_error(input string what);
    $display("Error at %0t: %s", $time, what);
    o_errors++;
  endtask

  // stall length is command, address, data and resume words plus the falling cycle
  task automatic accept_request(input core_req_t req);
    int                n;
    logic [MEM_AW-1:0] a;
    n = int'(req.count) + 1;
    case (req.kind)
      REQ_LOAD_PC: begin
        ref_pc     = req.addr;
        pc_loaded  = 1'b1;
        stall_left = 1 + ADDR_NIBS + 1;
      end
      REQ_DP_READ: begin
        for (int i = 0; i < n; i++) begin
          rd_addrs.push_back(MEM_AW'(req.addr) + MEM_AW'(i));
        end
        stall_left = 1 + ADDR_NIBS + n + 1 + 1;
      end
      REQ_DP_WRITE: begin
        for (int i = 0; i < n; i++) begin
          a          = MEM_AW'(req.addr) + MEM_AW'(i);
          ref_mem[a] = req.wdata[4*i +: 4];
          written[a] = 1'b1;
        end
        stall_left = 1 + ADDR_NIBS + 1 + n + 1 + 1;
      end
      default: protocol_error("request of unknown kind accepted");
    endcase
  endtask

  always @(posedge i_clk) begin
    if (do_cmd_reset) begin
      o_errors   = 0;
      o_checks   = 0;
      ref_pc     = '0;
      pc_loaded  = 1'b0;
      fetch_pipe = '0;
      stall_left = 0;
      rd_addrs.delete();
      foreach (written[a]) begin
        written[a] = 1'b0;
      end
    end else begin
      exp_stall = (stall_left != 0);
      check_value("o_stalled_by_bus", 32'(i_stalled), 32'(exp_stall));
      if (i_nibble_valid && i_nibble_is_data) begin
        if (rd_addrs.size() == 0) begin
          protocol_error("data nibble with no DP_READ outstanding");
        end else begin
          idx = rd_addrs.pop_front();
          if (written[idx]) check_value("o_nibble (data)", 32'(i_nibble), 32'(ref_mem[idx]));
        end
      end else if (i_nibble_valid) begin
        if (!fetch_pipe[1]) begin
          protocol_error("fetch nibble where none was expected");
        end else begin
          idx    = ref_pc[MEM_AW-1:0];
          ref_pc = ref_pc + 1'b1;
          if (written[idx]) check_value("o_nibble (fetch)", 32'(i_nibble), 32'(ref_mem[idx]));
        end
      end else if (fetch_pipe[1]) begin
        protocol_error("fetch nibble missing two cycles after i_fetch");
      end
      // fetch nibble lands two cycles after a free bus sees i_fetch
      fetch_pipe = {fetch_pipe[0], i_fetch && !exp_stall && pc_loaded && !i_req_valid};
      if (stall_left > 0) begin
        stall_left--;
        if (stall_left == 0 && rd_addrs.size() != 0) begin
          protocol_error("stall dropped with DP_READ data nibbles missing");
          rd_addrs.delete();
        end
      end
      if (i_req_valid && !exp_stall) accept_request(i_req);
    end
  end

endmodule

//--- tests/tb_saturn_bus.sv
`timescale 1ns/10ps

module tb_saturn_bus;

  import saturn_core_pkg::*;

  localparam int N_FILL       = 8;
  localparam int FILL_NIBS    = 8;
  localparam int N_MIX        = 60;
  localparam int MAX_BURST    = 12;
  // DP traffic stays inside the window the fill writes cover
  localparam int WIN_NIBS     = N_FILL * FILL_NIBS;
  localparam int N_REQS       = N_FILL + N_MIX;
  localparam int FETCH_CYCLES = (N_MIX + 1) * (MAX_BURST + 2);
  localparam int CYCLE_LIMIT  = (N_REQS * 40 + FETCH_CYCLES) * 2;

  logic              i_clk;
  logic              do_cmd_reset;
  core_req_t         req;
  logic              req_valid;
  logic              fetch;
  logic              stalled;
  logic [3:0]        nibble;
  logic              nibble_valid;
  logic              nibble_is_data;
  int                sb_errors;
  int                sb_checks;
  int                cycles = 0;
  integer            seed = 32'hb37c;
  logic [MEM_AW-1:0] win_base;
  int                kind_sel;
  int                nibs;
  int                offset;

  saturn_bus_top dut (
    .i_clk            (i_clk),
    .do_cmd_reset     (do_cmd_reset),
    .i_req            (req),
    .i_req_valid      (req_valid),
    .i_fetch          (fetch),
    .o_stalled_by_bus (stalled),
    .o_nibble         (nibble),
    .o_nibble_valid   (nibble_valid),
    .o_nibble_is_data (nibble_is_data)
  );

  bus_scoreboard u_scoreboard (
    .i_clk            (i_clk),
    .do_cmd_reset     (do_cmd_reset),
    .i_req            (req),
    .i_req_valid      (req_valid),
    .i_fetch          (fetch),
    .i_stalled        (stalled),
    .i_nibble         (nibble),
    .i_nibble_valid   (nibble_valid),
    .i_nibble_is_data (nibble_is_data),
    .o_errors         (sb_errors),
    .o_checks         (sb_checks)
  );

  bind bus_cmd_sequencer saturn_bus_chk u_chk (
    .i_clk        (i_clk),
    .do_cmd_reset (do_cmd_reset),
    .i_accept     (o_accept),
    .i_stalled    (o_stalled_by_bus),
    .i_bus        (o_bus)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // upper bits vary since the device only sees the address modulo its depth
  function automatic logic [REQ_AW-1:0] window_addr(input int off);
    logic [REQ_AW-1:0] upper;
    upper = REQ_AW'($random(seed));
    return {upper[REQ_AW-1:MEM_AW], win_base + MEM_AW'(off)};
  endfunction

  function automatic int total_errors();
    return sb_errors + dut.u_sequencer.u_chk.fail_count;
  endfunction

  task automatic report_counts();
    $display("checks: %0d, scoreboard errors: %0d, assertion errors: %0d",
             sb_checks, sb_errors, dut.u_sequencer.u_chk.fail_count);
  endtask

  // called on a falling edge, returns once the bus is free again
  task automatic send_request(input req_kind_e kind, input logic [REQ_AW-1:0] addr,
                              input int n);
    while (stalled) @(negedge i_clk);
    req.kind  = kind;
    req.addr  = addr;
    req.count = CNT_W'(n - 1);
    req.wdata = {$random(seed), $random(seed)};
    req_valid = 1'b1;
    @(negedge i_clk);
    req_valid = 1'b0;
    // core may keep asking for fetch while the bus is busy
    fetch     = (rand_below(2) == 1);
    while (stalled) @(negedge i_clk);
  endtask

  task automatic fetch_burst(input int len);
    fetch = 1'b1;
    repeat (len) @(negedge i_clk);
    fetch = 1'b0;
    // last fetch nibble lands before the next request
    repeat (2) @(negedge i_clk);
  endtask

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      report_counts();
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    do_cmd_reset = 1'b1;
    req          = '0;
    req_valid    = 1'b0;
    fetch        = 1'b0;
    win_base     = MEM_AW'($random(seed));
    repeat (16) @(negedge i_clk);
    do_cmd_reset = 1'b0;
    // no PC loaded yet, so fetch returns nothing
    fetch_burst(8);
    for (int i = 0; i < N_FILL; i++) begin
      send_request(REQ_DP_WRITE, window_addr(i * FILL_NIBS), FILL_NIBS);
    end
    for (int i = 0; i < N_MIX; i++) begin
      kind_sel = rand_below(3);
      nibs     = 1 + rand_below(MAX_XFER);
      offset   = rand_below(WIN_NIBS - nibs + 1);
      case (kind_sel)
        0: send_request(REQ_LOAD_PC, window_addr(offset), 1);
        1: send_request(REQ_DP_READ, window_addr(offset), nibs);
        default: send_request(REQ_DP_WRITE, window_addr(offset), nibs);
      endcase
      fetch_burst(1 + rand_below(MAX_BURST));
    end
    repeat (4) @(negedge i_clk);
    report_counts();
    if (total_errors() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- src.f
hw/saturn_bus_pkg.sv
hw/saturn_core_pkg.sv
hw/bus_req_capture.sv
hw/bus_cmd_sequencer.sv
hw/bus_nibble_memory.sv
hw/saturn_bus_top.sv
tests/saturn_bus_chk.sv
tests/bus_scoreboard.sv
tests/tb_saturn_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_saturn_bus -f src.f \
  && ./obj_dir/Vtb_saturn_bus +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -q "All checks passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
